/* Makefile */
TOP := tb_soc_periph
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
source/soc_bus_pkg.sv
source/soc_map_pkg.sv
source/apb_decoder.sv
source/scratch_ram.sv
source/led_port.sv
source/tick_timer.sv
source/soc_periph_top.sv
tb/tb_clock_gen.sv
tb/soc_periph_asserts.sv
tb/tb_soc_periph.sv

/* source/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
	input  wire                   clock,
	input  wire                   i_rst_n,
	input  soc_bus_pkg::apb_req_t i_apb,
	output soc_bus_pkg::apb_rsp_t o_apb,
	output soc_bus_pkg::apb_req_t o_ram_req,
	output soc_bus_pkg::apb_req_t o_led_req,
	output soc_bus_pkg::apb_req_t o_tmr_req,
	input  soc_bus_pkg::slv_rsp_t i_ram_rsp,
	input  soc_bus_pkg::slv_rsp_t i_led_rsp,
	input  soc_bus_pkg::slv_rsp_t i_tmr_rsp
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	apb_state_e state_q;
	apb_state_e state_d;
	region_e    region_q;
	region_e    region_sel;
	logic       active;
	logic       access;
	logic       setup;
	apb_rsp_t   rsp;

	function automatic region_e region_of(addr_t a);
		case (a[31:28])
			4'h1:    region_of = REG_RAM;
			4'h4:    region_of = REG_LED;
			4'hA:    region_of = REG_TMR;
			default: region_of = REG_NONE;
		endcase
	endfunction

	assign active = (state_q != ST_IDLE);
	assign setup  = (state_q == ST_IDLE) && i_apb.psel && !i_apb.penable;
	assign access = active && i_apb.psel && i_apb.penable;

	// Setup cycle decodes live, access cycles use the latched region
	assign region_sel = active ? region_q : region_of(i_apb.paddr);

	// ====================
	// Phase tracking
	// ====================

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
				if (setup)
					state_d = ST_SETUP;
			default:
				if (rsp.pready || !i_apb.psel)
					state_d = ST_IDLE;
				else
					state_d = ST_ACCESS;
		endcase
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state_q  <= ST_IDLE;
			region_q <= REG_NONE;
		end
		else
		begin
			state_q <= state_d;
			if (setup)
				region_q <= region_of(i_apb.paddr);
		end
	end

	// ====================
	// Request fan-out
	// ====================

	always_comb
	begin
		o_ram_req      = i_apb;
		o_led_req      = i_apb;
		o_tmr_req      = i_apb;
		o_ram_req.psel = i_apb.psel && (region_sel == REG_RAM);
		o_led_req.psel = i_apb.psel && (region_sel == REG_LED);
		o_tmr_req.psel = i_apb.psel && (region_sel == REG_TMR);
	end

	// Response mux, unmapped regions answer at once with an error
	always_comb
	begin
		rsp = '0;
		if (access)
		begin
			case (region_q)
				REG_RAM: {rsp.prdata, rsp.pready} = i_ram_rsp;
				REG_LED: {rsp.prdata, rsp.pready} = i_led_rsp;
				REG_TMR: {rsp.prdata, rsp.pready} = i_tmr_rsp;
				default:
				begin
					rsp.pready  = 1'b1;
					rsp.pslverr = 1'b1;
				end
			endcase
		end
	end

	assign o_apb = rsp;

endmodule

`default_nettype wire

/* source/led_port.sv */
`timescale 1ns/1ps
`default_nettype none

module led_port (
	input  wire                   clock,
	input  wire                   i_rst_n,
	input  soc_bus_pkg::apb_req_t i_req,
	output soc_bus_pkg::slv_rsp_t o_rsp,
	output soc_map_pkg::led_t     o_leds
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	led_t leds_q;
	led_t mask;
	logic wr_en;

	assign wr_en = i_req.psel && i_req.penable && i_req.pwrite;
	assign mask  = i_req.pwdata[LED_WIDTH-1:0];

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			leds_q <= '0;
		else if (wr_en)
		begin
			case (i_req.paddr[3:2])
				OFS_VALUE:  leds_q <= mask;
				OFS_SET:    leds_q <= leds_q | mask;
				OFS_CLEAR:  leds_q <= leds_q & ~mask;
				OFS_TOGGLE: leds_q <= leds_q ^ mask;
				default:    leds_q <= leds_q;
			endcase
		end
	end

	// Zero wait states, all offsets read the vector
	assign o_rsp.prdata = word_t'(leds_q);
	assign o_rsp.pready = i_req.psel && i_req.penable;
	assign o_leds       = leds_q;

endmodule

`default_nettype wire

/* source/scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
	input  wire                   clock,
	input  wire                   i_rst_n,
	input  soc_bus_pkg::apb_req_t i_req,
	output soc_bus_pkg::slv_rsp_t o_rsp
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	word_t      mem [RAM_WORDS];
	word_t      rdata_q;
	logic       rd_valid_q;
	logic       access;
	ram_index_t index;

	assign access = i_req.psel && i_req.penable;
	// Word addressed, byte offset bits ignored
	assign index  = i_req.paddr[10:2];

	// Array and read register
	always_ff @(posedge clock)
	begin
		if (access && i_req.pwrite)
			mem[index] <= i_req.pwdata;
		if (access && !i_req.pwrite && !rd_valid_q)
			rdata_q <= mem[index];
	end

	// Read wait state
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			rd_valid_q <= 1'b0;
		else if (rd_valid_q)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= access && !i_req.pwrite;
	end

	assign o_rsp.prdata = rdata_q;
	assign o_rsp.pready = access && (i_req.pwrite || rd_valid_q);

endmodule

`default_nettype wire

/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

	// ====================
	// APB word types
	// ====================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// Master side request, one copy per slave after decode
	typedef struct packed {
		addr_t paddr;
		logic  psel;
		logic  penable;
		logic  pwrite;
		word_t pwdata;
	} apb_req_t;

	// Response seen by the master
	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	// Slave answer, errors come only from the decoder
	typedef struct packed {
		word_t prdata;
		logic  pready;
	} slv_rsp_t;

	// Decoder phase tracking
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_SETUP  = 2'd1,
		ST_ACCESS = 2'd2
	} apb_state_e;

endpackage

`default_nettype wire

/* source/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

	// ====================
	// Address map
	// ====================

	// Region code from address bits 31..28
	typedef enum logic [3:0] {
		REG_NONE = 4'h0,
		REG_RAM  = 4'h1,
		REG_LED  = 4'h4,
		REG_TMR  = 4'hA
	} region_e;

	// Scratch RAM, word addressed
	localparam int RAM_WORDS = 512;
	typedef logic [8:0] ram_index_t;

	// LED port
	localparam int LED_WIDTH = 10;
	typedef logic [LED_WIDTH-1:0] led_t;

	// Register offsets, address bits 3..2
	localparam logic [1:0] OFS_VALUE   = 2'd0;
	localparam logic [1:0] OFS_SET     = 2'd1;
	localparam logic [1:0] OFS_CLEAR   = 2'd2;
	localparam logic [1:0] OFS_TOGGLE  = 2'd3;
	localparam logic [1:0] OFS_CTRL    = 2'd0;
	localparam logic [1:0] OFS_COMPARE = 2'd1;
	localparam logic [1:0] OFS_COUNT   = 2'd2;
	localparam logic [1:0] OFS_STATUS  = 2'd3;

	// Timer prescaler, clocks per tick
	localparam int TICK_DIV = 4;
	localparam int TICK_W   = $clog2(TICK_DIV);
	typedef logic [TICK_W-1:0] presc_t;

endpackage

`default_nettype wire

/* source/soc_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top (
	input  wire                   clock,
	input  wire                   i_rst_n,
	input  soc_bus_pkg::apb_req_t i_apb,
	output soc_bus_pkg::apb_rsp_t o_apb,
	output soc_map_pkg::led_t     o_leds,
	output logic                  o_irq
);

	import soc_bus_pkg::*;

	apb_req_t ram_req;
	apb_req_t led_req;
	apb_req_t tmr_req;
	slv_rsp_t ram_rsp;
	slv_rsp_t led_rsp;
	slv_rsp_t tmr_rsp;

	// Region decode and response mux
	apb_decoder u_decoder (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_apb     (i_apb),
		.o_apb     (o_apb),
		.o_ram_req (ram_req),
		.o_led_req (led_req),
		.o_tmr_req (tmr_req),
		.i_ram_rsp (ram_rsp),
		.i_led_rsp (led_rsp),
		.i_tmr_rsp (tmr_rsp)
	);

	// ====================
	// Slaves
	// ====================

	scratch_ram u_ram (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	led_port u_led (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (led_req),
		.o_rsp   (led_rsp),
		.o_leds  (o_leds)
	);

	tick_timer u_timer (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (tmr_req),
		.o_rsp   (tmr_rsp),
		.o_irq   (o_irq)
	);

endmodule

`default_nettype wire

/* source/tick_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_timer (
	input  wire                   clock,
	input  wire                   i_rst_n,
	input  soc_bus_pkg::apb_req_t i_req,
	output soc_bus_pkg::slv_rsp_t o_rsp,
	output logic                  o_irq
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	presc_t     presc_q;
	word_t      count_q;
	word_t      compare_q;
	logic [1:0] ctrl_q;
	logic       pending_q;
	logic       access;
	logic       wr_en;
	logic       tick;
	logic       match;
	logic       clr_pend;
	logic [1:0] ofs;

	assign access   = i_req.psel && i_req.penable;
	assign wr_en    = access && i_req.pwrite;
	assign ofs      = i_req.paddr[3:2];
	// Bit 0 enable, bit 1 irq enable
	assign tick     = ctrl_q[0] && (presc_q == presc_t'(TICK_DIV - 1));
	assign match    = (count_q == compare_q);
	assign clr_pend = wr_en && (ofs == OFS_STATUS) && i_req.pwdata[0];

	// ====================
	// Prescaler and counter
	// ====================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			presc_q   <= '0;
			count_q   <= '0;
			compare_q <= '0;
			ctrl_q    <= '0;
			pending_q <= 1'b0;
		end
		else
		begin
			if (!ctrl_q[0] || tick)
				presc_q <= '0;
			else
				presc_q <= presc_q + 1'b1;

			// Bus write to count overrides the tick
			if (wr_en && ofs == OFS_COUNT)
				count_q <= i_req.pwdata;
			else if (tick)
				count_q <= match ? '0 : count_q + 1'b1;

			if (wr_en && ofs == OFS_CTRL)
				ctrl_q <= i_req.pwdata[1:0];
			if (wr_en && ofs == OFS_COMPARE)
				compare_q <= i_req.pwdata;

			// New match wins over a clear in the same cycle
			if (tick && match)
				pending_q <= 1'b1;
			else if (clr_pend)
				pending_q <= 1'b0;
		end
	end

	// Register readback
	always_comb
	begin
		case (ofs)
			OFS_CTRL:    o_rsp.prdata = word_t'(ctrl_q);
			OFS_COMPARE: o_rsp.prdata = compare_q;
			OFS_COUNT:   o_rsp.prdata = count_q;
			default:     o_rsp.prdata = word_t'(pending_q);
		endcase
	end

	assign o_rsp.pready = access;
	assign o_irq        = pending_q && ctrl_q[1];

endmodule

`default_nettype wire

/* tb/soc_periph_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_asserts (
	input wire                   clock,
	input wire                   i_rst_n,
	input soc_bus_pkg::apb_req_t i_apb,
	input soc_bus_pkg::apb_rsp_t i_rsp,
	input wire                   i_irq
);

	import soc_map_pkg::*;

	int unsigned fail_count = 0;
	logic        irq_en_seen;

	// Irq enable as last written over the bus to timer ctrl
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			irq_en_seen <= 1'b0;
		else if (i_apb.psel && i_apb.penable && i_apb.pwrite && i_rsp.pready
			&& i_apb.paddr[31:28] == REG_TMR && i_apb.paddr[3:2] == OFS_CTRL)
			irq_en_seen <= i_apb.pwdata[1];
	end

	// Master holds the transfer while the slave inserts wait states
	property hold_while_waiting;
		@(posedge clock) disable iff (!i_rst_n)
		(i_apb.psel && i_apb.penable && !i_rsp.pready) |=>
			(i_apb.psel && i_apb.penable && $stable(i_apb.paddr)
				&& $stable(i_apb.pwrite) && $stable(i_apb.pwdata));
	endproperty

	// Error response comes with pready and only for unmapped regions
	property error_with_ready;
		@(posedge clock) disable iff (!i_rst_n)
		i_rsp.pslverr |-> (i_rsp.pready && i_apb.psel && i_apb.penable
			&& i_apb.paddr[31:28] != REG_RAM && i_apb.paddr[31:28] != REG_LED
			&& i_apb.paddr[31:28] != REG_TMR);
	endproperty

	// Interrupt is masked by irq enable
	property irq_masked;
		@(posedge clock) disable iff (!i_rst_n)
		!irq_en_seen |-> !i_irq;
	endproperty

	a_hold : assert property (hold_while_waiting)
	else
	begin
		$error("APB request changed while the transfer was waiting");
		fail_count++;
	end

	a_slverr : assert property (error_with_ready)
	else
	begin
		$error("pslverr was high without pready or for a mapped region");
		fail_count++;
	end

	a_irq : assert property (irq_masked)
	else
	begin
		$error("o_irq was high while irq enable was clear");
		fail_count++;
	end

endmodule

bind soc_periph_top soc_periph_asserts u_asserts (
	.clock    (clock),
	.i_rst_n  (i_rst_n),
	.i_apb    (i_apb),
	.i_rsp    (o_apb),
	.i_irq    (o_irq)
);

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic o_rst_n
);

	// 100 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// Reset held for 16 cycles, released on a falling edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (16)
			@(posedge clock);
		@(negedge clock);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* tb/tb_soc_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int WAIT_LIMIT = 20;
	localparam int IRQ_LIMIT  = 200;

	logic       clock;
	logic       rst_n;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	apb_rsp_t   rsp_q;
	led_t       leds;
	logic       irq;
	word_t      lfsr = 32'h6134_54ce;
	word_t      ram_data [16];
	ram_index_t ram_idx [16];

	tb_clock_gen u_clock_gen (
		.clock   (clock),
		.o_rst_n (rst_n)
	);

	soc_periph_top DUT (
		.clock   (clock),
		.i_rst_n (rst_n),
		.i_apb   (apb_req),
		.o_apb   (apb_rsp),
		.o_leds  (leds),
		.o_irq   (irq)
	);

	// Response as seen at the rising edge
	always @(posedge clock)
		rsp_q <= apb_rsp;

	// ====================
	// Helpers
	// ====================

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		assert (got === exp)
		else
			fail_now($sformatf("Error: %s expected %h actual %h", name, exp, got));
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic word_t lfsr_next(input word_t state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic take_bits(input int count, output word_t value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	function automatic addr_t reg_addr(input logic [3:0] region, input logic [25:0] word_ofs);
		return {region, word_ofs, 2'b00};
	endfunction

	// One APB transfer, setup then access until pready
	task automatic apb_transfer(input addr_t addr, input logic write, input word_t wdata,
		output word_t rdata, output logic err);
		int waited;
		@(negedge clock);
		apb_req.paddr   = addr;
		apb_req.pwrite  = write;
		apb_req.pwdata  = wdata;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clock);
		apb_req.penable = 1'b1;
		waited = 0;
		@(negedge clock);
		while (!rsp_q.pready)
		begin
			if (waited == WAIT_LIMIT)
				fail_now($sformatf("Timeout: no pready for the transfer to %h", addr));
			waited++;
			@(negedge clock);
		end
		rdata           = rsp_q.prdata;
		err             = rsp_q.pslverr;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(input string name, input addr_t addr, input word_t data,
		input logic exp_err);
		word_t rdata;
		logic  err;
		apb_transfer(addr, 1'b1, data, rdata, err);
		check_word($sformatf("%s pslverr", name), word_t'(exp_err), word_t'(err));
	endtask

	task automatic apb_read(input string name, input addr_t addr, input logic exp_err,
		output word_t data);
		logic err;
		apb_transfer(addr, 1'b0, '0, data, err);
		check_word($sformatf("%s pslverr", name), word_t'(exp_err), word_t'(err));
	endtask

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		int                   waited;
		word_t                rnd;
		word_t                rdata;
		word_t                count_before;
		ram_index_t           idx;
		led_t                 led_model;
		logic [RAM_WORDS-1:0] used;

		apb_req = '0;
		used    = '0;
		waited  = 0;
		while (rst_n !== 1'b1)
		begin
			if (waited == 40)
				fail_now("Timeout: reset was never released");
			waited++;
			@(negedge clock);
		end

		// Reset values
		check_word("reset leds", '0, word_t'(leds));
		check_word("reset irq", '0, word_t'(irq));
		apb_read("reset status", reg_addr(REG_TMR, 26'(OFS_STATUS)), 1'b0, rdata);
		check_word("reset status", '0, rdata);

		// RAM round trip at distinct random indexes
		for (int i = 0; i < 16; i++)
		begin
			take_bits(9, rnd);
			idx = ram_index_t'(rnd);
			while (used[idx])
				idx = idx + 1'b1;
			used[idx]  = 1'b1;
			ram_idx[i] = idx;
			take_bits(32, ram_data[i]);
			apb_write("ram write", reg_addr(REG_RAM, 26'(idx)), ram_data[i], 1'b0);
		end
		for (int i = 0; i < 16; i++)
		begin
			apb_read("ram read", reg_addr(REG_RAM, 26'(ram_idx[i])), 1'b0, rdata);
			check_word($sformatf("ram index %0d", ram_idx[i]), ram_data[i], rdata);
		end

		// LED value, then set, clear and toggle
		take_bits(32, rnd);
		led_model = rnd[LED_WIDTH-1:0];
		apb_write("led value", reg_addr(REG_LED, 26'(OFS_VALUE)), rnd, 1'b0);
		check_word("led value pins", word_t'(led_model), word_t'(leds));
		for (int round = 0; round < 2; round++)
			for (int op = 1; op < 4; op++)
			begin
				take_bits(32, rnd);
				case (op)
					1:       led_model = led_model | rnd[LED_WIDTH-1:0];
					2:       led_model = led_model & ~rnd[LED_WIDTH-1:0];
					default: led_model = led_model ^ rnd[LED_WIDTH-1:0];
				endcase
				apb_write("led op", reg_addr(REG_LED, 26'(op)), rnd, 1'b0);
				check_word($sformatf("led op %0d pins", op), word_t'(led_model), word_t'(leds));
				apb_read("led readback", reg_addr(REG_LED, 26'(OFS_VALUE)), 1'b0, rdata);
				check_word($sformatf("led op %0d read", op), word_t'(led_model), rdata);
			end

		// Timer interrupt
		apb_write("timer compare", reg_addr(REG_TMR, 26'(OFS_COMPARE)), 32'd5, 1'b0);
		apb_write("timer ctrl", reg_addr(REG_TMR, 26'(OFS_CTRL)), 32'd3, 1'b0);
		waited = 0;
		while (!irq)
		begin
			if (waited == IRQ_LIMIT)
				fail_now("Timeout: the timer interrupt never rose");
			waited++;
			@(negedge clock);
		end
		apb_read("timer status", reg_addr(REG_TMR, 26'(OFS_STATUS)), 1'b0, rdata);
		check_word("timer status pending", 32'd1, rdata);
		apb_write("timer clear", reg_addr(REG_TMR, 26'(OFS_STATUS)), 32'd1, 1'b0);
		check_word("irq after clear", '0, word_t'(irq));
		apb_read("timer status", reg_addr(REG_TMR, 26'(OFS_STATUS)), 1'b0, rdata);
		check_word("timer status cleared", '0, rdata);
		apb_write("timer stop", reg_addr(REG_TMR, 26'(OFS_CTRL)), '0, 1'b0);
		apb_read("timer count", reg_addr(REG_TMR, 26'(OFS_COUNT)), 1'b0, count_before);

		// Unmapped region 0x6
		apb_read("unmapped read", reg_addr(4'h6, 26'h4), 1'b1, rdata);
		check_word("unmapped read data", '0, rdata);
		take_bits(32, rnd);
		apb_write("unmapped write", reg_addr(4'h6, 26'(ram_idx[0])), rnd, 1'b1);
		check_word("leds after unmapped", word_t'(led_model), word_t'(leds));
		apb_read("ram after unmapped", reg_addr(REG_RAM, 26'(ram_idx[0])), 1'b0, rdata);
		check_word("ram after unmapped", ram_data[0], rdata);
		apb_read("compare after unmapped", reg_addr(REG_TMR, 26'(OFS_COMPARE)), 1'b0, rdata);
		check_word("compare after unmapped", 32'd5, rdata);
		apb_read("count after unmapped", reg_addr(REG_TMR, 26'(OFS_COUNT)), 1'b0, rdata);
		check_word("count after unmapped", count_before, rdata);

		if (DUT.u_asserts.fail_count == 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
			fail_now("Protocol assertions failed during the run");
	end

endmodule

`default_nettype wire
